//--- s_edge_router.f
+incdir+hw
hw/noc_flit_pkg.sv
hw/noc_route_pkg.sv
hw/input_buffer.sv
hw/credit_counter.sv
hw/switch_arbiter.sv
hw/crossbar_switch.sv
hw/s_edge_router.sv
testbench/tb_clock_gen.sv
testbench/s_edge_router_props.sv
testbench/s_edge_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the router testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f s_edge_router.f \
  --top-module s_edge_router_tb -o s_edge_router_sim || exit 1
./obj_dir/s_edge_router_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "%Error" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

//--- testbench/s_edge_router_tb.sv
/* South-edge router testbench
   Directed and random flit traffic against a routing scoreboard */
`include "noc_macros.svh"

module s_edge_router_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import noc_flit_pkg::*;
  import noc_route_pkg::*;

  localparam int NP = `NOC_NUM_PORTS;
  localparam logic [2:0] ROUTER_Y = 3'd0;
  localparam logic [2:0] ROUTER_X = 3'd2;
  localparam int RAND_FLITS = 64;
  localparam int TOTAL_FLITS = 16 + 9 + 12 + 12 + RAND_FLITS;
  localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 20 + 1000;

  logic             clk;
  logic             rst_n;
  coord_t           router_addr;
  link_t  [NP-1:0]  link_i;
  logic   [NP-1:0]  credit_i;
  link_t  [NP-1:0]  link_o;
  logic   [NP-1:0]  credit_o;

  flit_t tx_q [NP][$];
  flit_t exp_q [NP*NP][$];
  flit_t rx_q [NP][$];
  int    east_src [$];
  int    up_credit [NP];
  int    owed_credit [NP];
  int    sent_count [NP];
  int    cr_count [NP];
  logic  auto_credit [NP];
  int    seq;
  int    seed = 32'he55b;
  int    errors;
  int    tests;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  s_edge_router UUT (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .router_addr_i (router_addr),
    .link_i        (link_i),
    .credit_i      (credit_i),
    .link_o        (link_o),
    .credit_o      (credit_o)
  );

  task automatic check_flit(flit_t exp, flit_t act, string name);
    if (act !== exp) begin
      $display("CHECK FAILED at %0d ns: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(int exp, int act, string name);
    if (act != exp) begin
      $display("CHECK FAILED at %0d ns: %s expected %0d got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(logic exp, logic act, string name);
    if (act !== exp) begin
      $display("CHECK FAILED at %0d ns: %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // YX order, and every other row lies to the north of this edge
  function automatic port_e predict_output(logic [2:0] dy, logic [2:0] dx);
    if (dy != ROUTER_Y) return PORT_N;
    if (dx > ROUTER_X) return PORT_E;
    if (dx < ROUTER_X) return PORT_W;
    return PORT_L;
  endfunction

  // Payload carries the source port and a running sequence number
  function automatic flit_t make_flit(flit_kind_e kind, logic [2:0] dy, logic [2:0] dx, int src);
    flit_t f;
    f.kind    = kind;
    f.dest_y  = dy;
    f.dest_x  = dx;
    f.payload = {2'(src), 6'(seq)};
    seq++;
    return f;
  endfunction

  task automatic queue_flit(int src, port_e out, flit_t f);
    tx_q[src].push_back(f);
    exp_q[src * NP + int'(out)].push_back(f);
  endtask

  task automatic send_single(int src, logic [2:0] dy, logic [2:0] dx);
    queue_flit(src, predict_output(dy, dx), make_flit(SINGLE, dy, dx, src));
  endtask

  task automatic send_packet(int src);
    queue_flit(src, predict_output(3'd0, 3'd5), make_flit(HEAD, 3'd0, 3'd5, src));
    queue_flit(src, PORT_E, make_flit(BODY, 3'd0, 3'd0, src));
    queue_flit(src, PORT_E, make_flit(BODY, 3'd0, 3'd0, src));
    queue_flit(src, PORT_E, make_flit(TAIL, 3'd0, 3'd0, src));
  endtask

  task automatic score(int o, flit_t f);
    int key;
    key = int'(f.payload[7:6]) * NP + o;
    if (exp_q[key].size() == 0) begin
      $display("Unexpected flit %h on output port %0d at %0d ns", f, o, $time);
      errors++;
    end else begin
      check_flit(exp_q[key].pop_front(), f, $sformatf("link_o[%0d].flit", o));
    end
  endtask

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int k = 0; k < NP * NP; k++) n += exp_q[k].size();
    return n;
  endfunction

  task automatic wait_drained();
    while (pending_flits() > 0) @(negedge clk);
    repeat (10) @(negedge clk);
  endtask

  task automatic wait_rx(int o, int n);
    while (rx_q[o].size() < n) @(negedge clk);
  endtask

  task automatic finish_test(string name);
    tests++;
    $display("Test %s finished, errors so far %0d", name, errors);
  endtask

  // Upstream senders and downstream credit return
  always @(posedge clk) begin
    for (int p = 0; p < NP; p++) begin
      credit_i[p] <= (owed_credit[p] > 0);
      if (owed_credit[p] > 0) owed_credit[p]--;
      link_i[p].valid <= 1'b0;
      if (tx_q[p].size() > 0 && up_credit[p] > 0) begin
        link_i[p].valid <= 1'b1;
        link_i[p].flit  <= tx_q[p].pop_front();
        up_credit[p]--;
        sent_count[p]++;
      end
    end
  end

  always @(negedge clk) begin
    for (int p = 0; p < NP; p++) begin
      if (rst_n && link_o[p].valid) begin
        rx_q[p].push_back(link_o[p].flit);
        if (p == int'(PORT_E)) east_src.push_back(int'(link_o[p].flit.payload[7:6]));
        if (auto_credit[p]) owed_credit[p]++;
        score(p, link_o[p].flit);
      end
      if (rst_n && credit_o[p]) begin
        up_credit[p]++;
        cr_count[p]++;
      end
    end
  end

  task automatic check_idle();
    for (int p = 0; p < NP; p++) begin
      check_bit(1'b0, link_o[p].valid, $sformatf("link_o[%0d].valid", p));
      check_bit(1'b0, credit_o[p], $sformatf("credit_o[%0d]", p));
    end
  endtask

  task automatic test_reset();
    @(posedge clk);
    @(negedge clk);
    check_idle();
    // First cycle after reset release
    @(negedge clk);
    check_idle();
    finish_test("reset");
  endtask

  task automatic test_routing();
    int base [NP];
    @(negedge clk);
    for (int p = 0; p < NP; p++) base[p] = rx_q[p].size();
    for (int s = 0; s < NP; s++) begin
      send_single(s, 3'd1, 3'd2);
      send_single(s, 3'd0, 3'd5);
      send_single(s, 3'd0, 3'd0);
      send_single(s, 3'd0, 3'd2);
    end
    wait_drained();
    for (int p = 0; p < NP; p++) begin
      check_count(4, rx_q[p].size() - base[p], $sformatf("link_o[%0d] flit count", p));
    end
    finish_test("routing");
  endtask

  task automatic test_wormhole();
    @(negedge clk);
    // W wins east once, so L is next in line
    send_single(PORT_W, 3'd0, 3'd5);
    wait_drained();
    east_src.delete();
    send_packet(PORT_W);
    send_packet(PORT_L);
    wait_drained();
    check_count(8, east_src.size(), "link_o[E] packet flits");
    if (east_src.size() == 8) begin
      for (int i = 0; i < 8; i++) begin
        check_count((i < 4) ? int'(PORT_L) : int'(PORT_W), east_src[i], "link_o[E] source");
      end
    end
    finish_test("wormhole");
  endtask

  task automatic test_backpressure();
    int base;
    @(negedge clk);
    auto_credit[PORT_E] = 1'b0;
    base = rx_q[PORT_E].size();
    for (int i = 0; i < 12; i++) send_single(PORT_L, 3'd0, 3'd5);
    wait_rx(PORT_E, base + `NOC_BUF_DEPTH);
    repeat (20) @(negedge clk);
    check_count(`NOC_BUF_DEPTH, rx_q[PORT_E].size() - base, "link_o[E] flits before stall");
    owed_credit[PORT_E] += 4;
    repeat (20) @(negedge clk);
    check_count(12, rx_q[PORT_E].size() - base, "link_o[E] flits after four credits");
    // Refill the east counter
    owed_credit[PORT_E] += `NOC_BUF_DEPTH;
    auto_credit[PORT_E] = 1'b1;
    wait_drained();
    finish_test("backpressure");
  endtask

  task automatic test_credit_return();
    @(negedge clk);
    for (int p = 0; p < NP; p++) begin
      sent_count[p] = 0;
      cr_count[p]   = 0;
    end
    for (int s = 0; s < NP; s++) begin
      send_single(s, 3'd1, 3'd2);
      send_single(s, 3'd0, 3'd5);
      send_single(s, 3'd0, 3'd0);
    end
    wait_drained();
    for (int p = 0; p < NP; p++) begin
      check_count(sent_count[p], cr_count[p], $sformatf("credit_o[%0d] pulses", p));
    end
    finish_test("credit_return");
  endtask

  task automatic test_random();
    int r;
    @(negedge clk);
    for (int i = 0; i < RAND_FLITS; i++) begin
      r = $random(seed);
      send_single(r & 3, (r[3:2] == 2'b00) ? 3'(r[6:4]) : ROUTER_Y, 3'(r[9:7]));
    end
    wait_drained();
    finish_test("random");
  endtask

  initial begin
    router_addr = '{y: ROUTER_Y, x: ROUTER_X};
    link_i      = '0;
    credit_i    = '0;
    for (int p = 0; p < NP; p++) begin
      up_credit[p]   = `NOC_BUF_DEPTH;
      auto_credit[p] = 1'b1;
    end
    test_reset();
    test_routing();
    test_wormhole();
    test_backpressure();
    test_credit_return();
    test_random();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- testbench/s_edge_router_props.sv
/* Credit counter checks
   Bound assertions on count range, decrements and reset state */
`include "noc_macros.svh"

module s_edge_router_props (
  input logic                     clk,
  input logic                     rst_n_i,
  input logic                     inc_i,
  input logic                     dec_i,
  input logic                     avail_i,
  input logic [`NOC_CREDIT_W-1:0] count_i
);

  timeunit 1ns;
  timeprecision 1ps;

  a_count_range : assert property (@(posedge clk) disable iff (!rst_n_i)
    count_i <= `NOC_CREDIT_W'(`NOC_BUF_DEPTH))
    else $error("credit count above buffer depth");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n_i)
    (dec_i && !inc_i) |-> (count_i != '0))
    else $error("credit decrement at zero count");

  a_avail_after_reset : assert property (@(posedge clk) !rst_n_i |=> avail_i)
    else $error("no credit available out of reset");

  // Grants only go to outputs that hold a credit
  a_dec_with_credit : assert property (@(posedge clk) disable iff (!rst_n_i)
    dec_i |-> avail_i)
    else $error("credit decrement without available credit");

endmodule

bind credit_counter s_edge_router_props u_props (
  .clk     (clk),
  .rst_n_i (rst_n_i),
  .inc_i   (inc_i),
  .dec_i   (dec_i),
  .avail_i (avail_o),
  .count_i (count)
);

//--- testbench/tb_clock_gen.sv
/* Testbench clock and reset
   40 ns clock, synchronous reset held low for two cycles */
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- hw/s_edge_router.sv
/* South-edge mesh router
   Four ports (N, E, W, L) with input buffers, credits, arbiter and crossbar */
`include "noc_macros.svh"

module s_edge_router (
  input  logic                                      clk,
  input  logic                                      rst_n_i,
  input  noc_route_pkg::coord_t                     router_addr_i,
  input  noc_flit_pkg::link_t  [`NOC_NUM_PORTS-1:0] link_i,
  input  logic                 [`NOC_NUM_PORTS-1:0] credit_i,
  output noc_flit_pkg::link_t  [`NOC_NUM_PORTS-1:0] link_o,
  output logic                 [`NOC_NUM_PORTS-1:0] credit_o
);

  import noc_flit_pkg::*;
  import noc_route_pkg::*;

  flit_t  [`NOC_NUM_PORTS-1:0] head;
  logic   [`NOC_NUM_PORTS-1:0] empty;
  logic   [`NOC_NUM_PORTS-1:0] avail;
  logic   [`NOC_NUM_PORTS-1:0] dec;
  grant_t [`NOC_NUM_PORTS-1:0] grant;

  // One buffer and one counter per port, indexed by port_e
  for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : g_port
    // A buffer read frees one upstream slot
    input_buffer u_ib (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .wr_i    (link_i[p].valid),
      .flit_i  (link_i[p].flit),
      .rd_i    (credit_o[p]),
      .flit_o  (head[p]),
      .empty_o (empty[p])
    );

    credit_counter u_cc (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .inc_i   (credit_i[p]),
      .dec_i   (dec[p]),
      .avail_o (avail[p])
    );
  end

  switch_arbiter u_arb (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .router_addr_i (router_addr_i),
    .head_i        (head),
    .empty_i       (empty),
    .avail_i       (avail),
    .read_o        (credit_o),
    .dec_o         (dec),
    .grant_o       (grant)
  );

  crossbar_switch u_xbar (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .head_i  (head),
    .grant_i (grant),
    .link_o  (link_o)
  );

endmodule

//--- hw/crossbar_switch.sv
/* Crossbar switch
   Selects the granted head flit per output and registers the link */
`include "noc_macros.svh"

module crossbar_switch (
  input  logic                                       clk,
  input  logic                                       rst_n_i,
  input  noc_flit_pkg::flit_t   [`NOC_NUM_PORTS-1:0] head_i,
  input  noc_route_pkg::grant_t [`NOC_NUM_PORTS-1:0] grant_i,
  output noc_flit_pkg::link_t   [`NOC_NUM_PORTS-1:0] link_o
);

  import noc_flit_pkg::*;

  logic  [`NOC_NUM_PORTS-1:0] valid_q;
  flit_t [`NOC_NUM_PORTS-1:0] flit_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
        valid_q[o] <= grant_i[o].valid;
      end
    end
  end

  // Data held while idle
  always_ff @(posedge clk) begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      if (grant_i[o].valid) begin
        flit_q[o] <= head_i[grant_i[o].src];
      end
    end
  end

  always_comb begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      link_o[o].valid = valid_q[o];
      link_o[o].flit  = flit_q[o];
    end
  end

endmodule

//--- hw/switch_arbiter.sv
/* Switch arbiter
   YX routing, wormhole locks and round-robin grant per output */
`include "noc_macros.svh"

module switch_arbiter (
  input  logic                                         clk,
  input  logic                                         rst_n_i,
  input  noc_route_pkg::coord_t                        router_addr_i,
  input  noc_flit_pkg::flit_t   [`NOC_NUM_PORTS-1:0]   head_i,
  input  logic                  [`NOC_NUM_PORTS-1:0]   empty_i,
  input  logic                  [`NOC_NUM_PORTS-1:0]   avail_i,
  output logic                  [`NOC_NUM_PORTS-1:0]   read_o,
  output logic                  [`NOC_NUM_PORTS-1:0]   dec_o,
  output noc_route_pkg::grant_t [`NOC_NUM_PORTS-1:0]   grant_o
);

  import noc_flit_pkg::*;
  import noc_route_pkg::*;

  localparam int NP     = `NOC_NUM_PORTS;
  localparam int PORT_W = $bits(port_e);

  port_e               req_port [NP];
  port_e               route_q  [NP];
  port_e               rr_ptr_q [NP];
  grant_t              lock_q   [NP];
  logic     [NP-1:0]   is_head;

  // Requested output of every input head flit
  always_comb begin
    for (int i = 0; i < NP; i++) begin
      is_head[i] = head_i[i].kind inside {HEAD, SINGLE};
      if (is_head[i]) begin
        req_port[i] = yx_route(head_i[i], router_addr_i);
      end else begin
        req_port[i] = route_q[i];
      end
    end
  end

  always_comb begin
    port_e cand;
    port_e idx;
    logic  found;
    grant_o = '0;
    read_o  = '0;
    dec_o   = '0;
    for (int o = 0; o < NP; o++) begin
      cand  = PORT_N;
      idx   = PORT_N;
      found = 1'b0;
      if (lock_q[o].valid) begin
        // Locked output only serves the rest of its packet
        cand  = lock_q[o].src;
        found = !empty_i[cand] && !is_head[cand] && (req_port[cand] == port_e'(o));
      end else begin
        for (int k = 0; k < NP; k++) begin
          idx = port_e'(rr_ptr_q[o] + PORT_W'(k));
          if (!found && !empty_i[idx] && is_head[idx] && (req_port[idx] == port_e'(o))) begin
            found = 1'b1;
            cand  = idx;
          end
        end
      end
      if (found && avail_i[o]) begin
        grant_o[o].valid = 1'b1;
        grant_o[o].src   = cand;
        read_o[cand]     = 1'b1;
        dec_o[o]         = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int o = 0; o < NP; o++) begin
        lock_q[o]   <= '0;
        rr_ptr_q[o] <= PORT_N;
        route_q[o]  <= PORT_L;
      end
    end else begin
      for (int o = 0; o < NP; o++) begin
        if (grant_o[o].valid) begin
          // Search restarts after the winner
          rr_ptr_q[o] <= port_e'(grant_o[o].src + 1'b1);
          case (head_i[grant_o[o].src].kind)
            HEAD: begin
              lock_q[o].valid              <= 1'b1;
              lock_q[o].src                <= grant_o[o].src;
              route_q[grant_o[o].src]      <= port_e'(o);
            end
            TAIL:    lock_q[o].valid <= 1'b0;
            default: ;
          endcase
        end
      end
    end
  end

endmodule

//--- hw/credit_counter.sv
/* Output credit counter
   Tracks free slots in the downstream buffer of one output */
`include "noc_macros.svh"

module credit_counter (
  input  logic clk,
  input  logic rst_n_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic avail_o
);

  logic [`NOC_CREDIT_W-1:0] count;

  // Downstream buffer starts empty
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count <= `NOC_CREDIT_W'(`NOC_BUF_DEPTH);
    end else begin
      case ({inc_i, dec_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign avail_o = (count != '0);

endmodule

//--- hw/input_buffer.sv
/* Input flit buffer
   First-word-fall-through circular FIFO for one router input */
`include "noc_macros.svh"

module input_buffer (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                wr_i,
  input  noc_flit_pkg::flit_t flit_i,
  input  logic                rd_i,
  output noc_flit_pkg::flit_t flit_o,
  output logic                empty_o
);

  import noc_flit_pkg::*;

  localparam int PTR_W = $clog2(`NOC_BUF_DEPTH);

  flit_t                    mem [`NOC_BUF_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [`NOC_CREDIT_W-1:0] count;
  logic                     do_wr;
  logic                     do_rd;

  // Overflow and underflow are dropped, credits keep them from happening
  assign do_wr = wr_i && (count != `NOC_CREDIT_W'(`NOC_BUF_DEPTH));
  assign do_rd = rd_i && (count != '0);

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= flit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head flit shown without a read cycle
  assign flit_o  = mem[rd_ptr];
  assign empty_o = (count == '0);

endmodule

//--- hw/noc_route_pkg.sv
/* Routing types
   Port index, router address, per-output grant and the YX route */
`include "noc_macros.svh"

package noc_route_pkg;

  import noc_flit_pkg::*;

  typedef enum logic [1:0] {
    PORT_N = 2'd0,
    PORT_E = 2'd1,
    PORT_W = 2'd2,
    PORT_L = 2'd3
  } port_e;

  typedef struct packed {
    logic [`NOC_COORD_W-1:0] y;
    logic [`NOC_COORD_W-1:0] x;
  } coord_t;

  typedef struct packed {
    logic  valid;
    port_e src;
  } grant_t;

  // Y first; no south port on this edge, so any other row goes north
  function automatic port_e yx_route(flit_t f, coord_t here);
    if (f.dest_y != here.y) return PORT_N;
    if (f.dest_x > here.x) return PORT_E;
    if (f.dest_x < here.x) return PORT_W;
    return PORT_L;
  endfunction

endpackage

//--- hw/noc_flit_pkg.sv
/* Flit-level types
   Flit kind, 16-bit flit and the valid-qualified link */
`include "noc_macros.svh"

package noc_flit_pkg;

  typedef enum logic [1:0] {
    HEAD   = 2'd0,
    BODY   = 2'd1,
    TAIL   = 2'd2,
    SINGLE = 2'd3
  } flit_kind_e;

  // Destination fields only meaningful for HEAD and SINGLE
  typedef struct packed {
    flit_kind_e              kind;
    logic [`NOC_COORD_W-1:0] dest_y;
    logic [`NOC_COORD_W-1:0] dest_x;
    logic [7:0]              payload;
  } flit_t;

  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

endpackage

//--- hw/noc_macros.svh
/* NoC sizing macros
   Buffer depth, credit width, port count and coordinate width */
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Flits per input buffer, also the reset credit of each output
`define NOC_BUF_DEPTH 8

// Must hold the value NOC_BUF_DEPTH
`define NOC_CREDIT_W 4

// N, E, W and L
`define NOC_NUM_PORTS 4

// Width of each mesh coordinate
`define NOC_COORD_W 3

`endif
